//--- src/csam_pkg.sv
`default_nettype none

// Shared widths, row counts and the state record that moves down the
// multiplier pipeline.
package csam_pkg;

        localparam int OPERAND_WIDTH = 16;
        localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

        // Rows 0 and 1 meet in the half-adder row.
        // Every row after that goes through a row of full adders.
        localparam int FIRST_FA_ROW = 2;
        localparam int FA_ROWS      = OPERAND_WIDTH - FIRST_FA_ROW;

        typedef logic [OPERAND_WIDTH-1:0] operand_t;
        typedef logic [PRODUCT_WIDTH-1:0] product_t;

        // The top bit of a sum row is the leftmost partial-product bit of the row
        // just reduced, which has nothing to add against yet.
        typedef logic [OPERAND_WIDTH-1:0] sum_row_t;
        typedef logic [OPERAND_WIDTH-2:0] carry_row_t;

        // Bit r holds product bit r once row r has been reduced.
        typedef logic [OPERAND_WIDTH-1:0] low_bits_t;

        // The operands travel along so that each stage can form its own
        // partial products.
        typedef struct packed {
                logic       valid;
                operand_t   x;
                operand_t   y;
                sum_row_t   sum_row;
                carry_row_t carry_row;
                low_bits_t  low_bits;
        } csa_state_t;

endpackage

`default_nettype wire

//--- src/csam_first_row.sv
`default_nettype none

module csam_first_row (
        input  logic                 clk,
        input  logic                 rst_n,
        input  csam_pkg::operand_t   x,
        input  csam_pkg::operand_t   y,
        input  logic                 in_valid,
        output csam_pkg::csa_state_t state
);

        import csam_pkg::*;

        operand_t   pp_row0;
        operand_t   pp_row1;
        sum_row_t   sum_row;
        carry_row_t carry_row;
        low_bits_t  low_bits;
        csa_state_t next_state;
        csa_state_t data_q;
        logic       valid_q;

        // Partial products of the two lowest multiplier bits.
        assign pp_row0 = x & {OPERAND_WIDTH{y[0]}};
        assign pp_row1 = x & {OPERAND_WIDTH{y[1]}};

        // Row 1 sits one column to the left of row 0, so bit i of row 1
        // meets bit i+1 of row 0 in a half adder.
        always_comb begin
                sum_row[OPERAND_WIDTH-2:0] = pp_row1[OPERAND_WIDTH-2:0] ^
                                             pp_row0[OPERAND_WIDTH-1:1];
                carry_row = pp_row1[OPERAND_WIDTH-2:0] & pp_row0[OPERAND_WIDTH-1:1];
                sum_row[OPERAND_WIDTH-1] = pp_row1[OPERAND_WIDTH-1]; // No partner.
        end

        // Product bits 0 and 1 are final already. The segments fill in the rest.
        always_comb begin
                low_bits    = '0;
                low_bits[0] = pp_row0[0];
                low_bits[1] = sum_row[0];
        end

        always_comb begin
                next_state.valid     = in_valid;
                next_state.x         = x;
                next_state.y         = y;
                next_state.sum_row   = sum_row;
                next_state.carry_row = carry_row;
                next_state.low_bits  = low_bits;
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        valid_q <= 1'b0;
                end else begin
                        valid_q <= in_valid;
                end
        end

        always_ff @(posedge clk) begin
                data_q <= next_state;
        end

        // The valid bit comes from the reset flop, the rest from the data flops.
        always_comb begin
                state       = data_q;
                state.valid = valid_q;
        end

endmodule

`default_nettype wire

//--- src/csam_row_segment.sv
`default_nettype none

module csam_row_segment #(
        parameter int FIRST_ROW        = 2,
        parameter int ROWS_PER_SEGMENT = 7
) (
        input  logic                 clk,
        input  logic                 rst_n,
        input  csam_pkg::csa_state_t state_in,
        output csam_pkg::csa_state_t state_out
);

        import csam_pkg::*;

        localparam int LAST_ROW = FIRST_ROW + ROWS_PER_SEGMENT - 1;

        csa_state_t next_state;
        csa_state_t data_q;
        logic       valid_q;

        // All rows of the segment are reduced in one combinational pass, each
        // row feeding the next, as in the plain array.
        always_comb begin
                operand_t   pp;
                sum_row_t   sum_cur;
                sum_row_t   sum_nxt;
                carry_row_t carry_cur;
                carry_row_t carry_nxt;
                low_bits_t  low_bits;

                sum_cur  = state_in.sum_row;
                carry_cur = state_in.carry_row;
                low_bits = state_in.low_bits;
                sum_nxt  = sum_cur;
                carry_nxt = carry_cur;

                for (int r = FIRST_ROW; r <= LAST_ROW; r++) begin
                        pp = state_in.x & {OPERAND_WIDTH{state_in.y[r]}};

                        // The previous sum row shifts one place right, since the
                        // new row starts one column further left.
                        sum_nxt[OPERAND_WIDTH-2:0] = pp[OPERAND_WIDTH-2:0] ^
                                                     sum_cur[OPERAND_WIDTH-1:1] ^
                                                     carry_cur;
                        carry_nxt = (pp[OPERAND_WIDTH-2:0] & sum_cur[OPERAND_WIDTH-1:1]) |
                                    (pp[OPERAND_WIDTH-2:0] & carry_cur) |
                                    (sum_cur[OPERAND_WIDTH-1:1] & carry_cur);
                        sum_nxt[OPERAND_WIDTH-1] = pp[OPERAND_WIDTH-1];

                        low_bits[r] = sum_nxt[0]; // Settled by this row.

                        sum_cur   = sum_nxt;
                        carry_cur = carry_nxt;
                end

                next_state           = state_in;
                next_state.sum_row   = sum_cur;
                next_state.carry_row = carry_cur;
                next_state.low_bits  = low_bits;
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        valid_q <= 1'b0;
                end else begin
                        valid_q <= state_in.valid;
                end
        end

        always_ff @(posedge clk) begin
                data_q <= next_state;
        end

        always_comb begin
                state_out       = data_q;
                state_out.valid = valid_q;
        end

endmodule

`default_nettype wire

//--- src/csam_final_adder.sv
`default_nettype none

module csam_final_adder (
        input  logic                 clk,
        input  logic                 rst_n,
        input  csam_pkg::csa_state_t state_in,
        output csam_pkg::product_t   product,
        output logic                 out_valid
);

        import csam_pkg::*;

        carry_row_t                 add_a;
        carry_row_t                 add_b;
        logic [OPERAND_WIDTH-1:0]   high_bits;
        product_t                   product_d;

        // The last carry row lines up with the sum row moved down one column.
        assign add_a = state_in.carry_row;
        assign add_b = state_in.sum_row[OPERAND_WIDTH-1:1];

        // Ripple carry-propagate adder over the upper half. Bit 0 has no carry
        // in, so it is a half adder.
        always_comb begin
                logic carry;

                carry = 1'b0;
                for (int i = 0; i < OPERAND_WIDTH - 1; i++) begin
                        high_bits[i] = add_a[i] ^ add_b[i] ^ carry;
                        carry = (add_a[i] & add_b[i]) |
                                (add_a[i] & carry) |
                                (add_b[i] & carry);
                end
                high_bits[OPERAND_WIDTH-1] = carry; // Top product bit.
        end

        assign product_d = {high_bits, state_in.low_bits};

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        out_valid <= 1'b0;
                end else begin
                        out_valid <= state_in.valid;
                end
        end

        // Held for one cycle only. The next vector overwrites it.
        always_ff @(posedge clk) begin
                product <= product_d;
        end

endmodule

`default_nettype wire

//--- src/csam16_pipe.sv
`default_nettype none

// Pipelined 16x16 unsigned carry-save array multiplier.
module csam16_pipe #(
        parameter int ROWS_PER_SEGMENT = 7
) (
        input  logic               clk,
        input  logic               rst_n,
        input  csam_pkg::operand_t x,
        input  csam_pkg::operand_t y,
        input  logic               in_valid,
        output csam_pkg::product_t product,
        output logic               out_valid
);

        import csam_pkg::*;

        // ROWS_PER_SEGMENT has to divide FA_ROWS evenly.
        localparam int NUM_SEGMENTS = FA_ROWS / ROWS_PER_SEGMENT;

        // Entry g feeds segment g. The last one feeds the final adder.
        csa_state_t seg_state [NUM_SEGMENTS+1];

        csam_first_row u_first_row (
                .clk      (clk),
                .rst_n    (rst_n),
                .x        (x),
                .y        (y),
                .in_valid (in_valid),
                .state    (seg_state[0])
        );

        for (genvar g = 0; g < NUM_SEGMENTS; g++) begin : g_segment
                csam_row_segment #(
                        .FIRST_ROW        (FIRST_FA_ROW + g * ROWS_PER_SEGMENT),
                        .ROWS_PER_SEGMENT (ROWS_PER_SEGMENT)
                ) u_row_segment (
                        .clk       (clk),
                        .rst_n     (rst_n),
                        .state_in  (seg_state[g]),
                        .state_out (seg_state[g+1])
                );
        end

        csam_final_adder u_final_adder (
                .clk       (clk),
                .rst_n     (rst_n),
                .state_in  (seg_state[NUM_SEGMENTS]),
                .product   (product),
                .out_valid (out_valid)
        );

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
`default_nettype none

// Free-running clock and a power-on reset that lasts a set number of cycles.
module clock_gen #(
        parameter int HALF_PERIOD  = 20,
        parameter int RESET_CYCLES = 2
) (
        output logic clk,
        output logic rst_n
);

        initial begin
                clk = 1'b0;
                forever #HALF_PERIOD clk = ~clk;
        end

        initial begin
                rst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk);
                rst_n <= 1'b1; // Released on a rising edge.
        end

endmodule

`default_nettype wire

//--- testbench/tb_csam16_pipe.sv
`default_nettype none

module tb_csam16_pipe;

        import csam_pkg::*;

        localparam int    ROWS_PER_SEGMENT = 7;
        localparam int    LATENCY          = 2 + FA_ROWS / ROWS_PER_SEGMENT;
        localparam int    RESET_CYCLES     = 2;
        localparam int    SETTLE_CYCLES    = 3;
        localparam int    NUM_RANDOM       = 200;
        localparam int    SEED             = 61123;
        localparam string VECTOR_FILE      = "testbench/csam_input.txt";

        logic     clk;
        logic     rst_n;
        operand_t x;
        operand_t y;
        logic     in_valid;
        product_t product;
        logic     out_valid;

        // Vectors to drive. The file vectors come first and the random ones after them.
        string    vec_name [$];
        operand_t vec_x [$];
        operand_t vec_y [$];
        int       vec_idle [$];

        // Results in flight. The oldest sits at the front.
        string    exp_name [$];
        product_t exp_value [$];
        int       exp_due [$];

        int cycle_count  = 0;
        int cycle_limit  = 0;
        int tests_passed = 0;
        int tests_failed = 0;
        int other_errors = 0;

        clock_gen #(
                .HALF_PERIOD  (20),
                .RESET_CYCLES (RESET_CYCLES)
        ) u_clock_gen (
                .clk   (clk),
                .rst_n (rst_n)
        );

        csam16_pipe #(
                .ROWS_PER_SEGMENT (ROWS_PER_SEGMENT)
        ) dut (
                .clk       (clk),
                .rst_n     (rst_n),
                .x         (x),
                .y         (y),
                .in_valid  (in_valid),
                .product   (product),
                .out_valid (out_valid)
        );

        // Unsigned product of two 16-bit factors.
        function automatic product_t expected_product(input operand_t a, input operand_t b);
                product_t wide_a;
                product_t wide_b;

                wide_a = a;
                wide_b = b;
                return wide_a * wide_b;
        endfunction

        task automatic read_vectors();
                int       fd;
                int       fields;
                int       line_no;
                int       idle;
                string    line;
                string    name;
                operand_t xv;
                operand_t yv;
                product_t listed;

                fd = $fopen(VECTOR_FILE, "r");
                if (fd == 0) begin
                        $display("Could not open the vector file %s", VECTOR_FILE);
                        other_errors++;
                        return;
                end
                line_no = 0;
                while ($fgets(line, fd) != 0) begin
                        line_no++;
                        if (line.len() > 1 && line.getc(0) != "#") begin
                                fields = $sscanf(line, "%s %h %h %h %d",
                                                 name, xv, yv, listed, idle);
                                if (fields != 5) begin
                                        $display("Vector file line %0d cannot be read", line_no);
                                        other_errors++;
                                end else begin
                                        // The listed product has to follow the rule as well.
                                        if (listed !== expected_product(xv, yv)) begin
                                                $display({"Vector file line %0d (%s) lists %h,",
                                                          " but %h * %h is %h"},
                                                         line_no, name, listed, xv, yv,
                                                         expected_product(xv, yv));
                                                other_errors++;
                                        end
                                        vec_name.push_back(name);
                                        vec_x.push_back(xv);
                                        vec_y.push_back(yv);
                                        vec_idle.push_back(idle);
                                end
                        end
                end
                $fclose(fd);
        endtask

        // Random vectors go back to back, with no idle cycles between them.
        task automatic add_random_vectors(input int count);
                logic [31:0] rnd;

                for (int i = 0; i < count; i++) begin
                        rnd = $urandom;
                        vec_name.push_back($sformatf("random_%0d", i));
                        vec_x.push_back(rnd[15:0]);
                        vec_y.push_back(rnd[31:16]);
                        vec_idle.push_back(0);
                end
        endtask

        task automatic drive_vector(input int idx);
                @(posedge clk);
                x        <= vec_x[idx];
                y        <= vec_y[idx];
                in_valid <= 1'b1;
                exp_name.push_back(vec_name[idx]);
                exp_value.push_back(expected_product(vec_x[idx], vec_y[idx]));
                // cycle_count still holds the count before this edge.
                exp_due.push_back(cycle_count + 1 + LATENCY);
                repeat (vec_idle[idx]) begin
                        @(posedge clk);
                        in_valid <= 1'b0;
                end
        endtask

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
                        $display("Timeout after %0d cycles with %0d results still pending",
                                 cycle_count, exp_name.size());
                        $display("SOME TESTS FAILED");
                        $finish;
                end
        end

        // Outputs are read at the falling edge, half a cycle after they change.
        always @(negedge clk) begin : check_output
                string    name;
                product_t expected;
                int       due;

                if (out_valid === 1'b1) begin
                        if (exp_name.size() == 0) begin
                                $display("out_valid went high at cycle %0d with nothing in flight",
                                         cycle_count);
                                other_errors++;
                        end else begin
                                name     = exp_name.pop_front();
                                expected = exp_value.pop_front();
                                due      = exp_due.pop_front();
                                if (product !== expected) begin
                                        $display("CHECK FAILED %s: expected %h, actual %h",
                                                 name, expected, product);
                                        tests_failed++;
                                end else if (cycle_count != due) begin
                                        $display("%s arrived at cycle %0d instead of cycle %0d",
                                                 name, cycle_count, due);
                                        tests_failed++;
                                end else begin
                                        $display("ok   %s  %h", name, product);
                                        tests_passed++;
                                end
                        end
                end else if (out_valid !== 1'b0 && rst_n === 1'b1) begin
                        $display("out_valid is unknown at cycle %0d", cycle_count);
                        other_errors++;
                end else if (exp_name.size() != 0 && exp_due[0] <= cycle_count) begin
                        name = exp_name.pop_front();
                        void'(exp_value.pop_front());
                        void'(exp_due.pop_front());
                        $display("%s gave no result at cycle %0d, where it was due",
                                 name, cycle_count);
                        tests_failed++;
                end
        end

        initial begin : main
                int idle_sum;
                int total;

                x        = '0;
                y        = '0;
                in_valid = 1'b0;
                void'($urandom(SEED));

                read_vectors();
                add_random_vectors(NUM_RANDOM);
                total    = vec_name.size();
                idle_sum = 0;
                foreach (vec_idle[i]) begin
                        idle_sum += vec_idle[i];
                end
                cycle_limit = RESET_CYCLES + SETTLE_CYCLES + total + idle_sum + LATENCY + 20;
                $display("Running %0d vectors, cycle limit %0d", total, cycle_limit);

                // A few quiet cycles after reset, where out_valid must stay low.
                wait (rst_n === 1'b1);
                repeat (SETTLE_CYCLES) @(posedge clk);

                for (int i = 0; i < total; i++) begin
                        drive_vector(i);
                end
                @(posedge clk);
                in_valid <= 1'b0;

                while (exp_name.size() != 0) begin
                        @(negedge clk);
                end
                repeat (2) @(posedge clk); // Room for a stray out_valid to show up.

                $display("Tests: %0d run, %0d passed, %0d failed, %0d other errors",
                         total, tests_passed, tests_failed, other_errors);
                if (tests_failed == 0 && other_errors == 0 && tests_passed == total) begin
                        $display("ALL TESTS PASSED");
                end else begin
                        $display("SOME TESTS FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- testbench/csam_input.txt
# Columns: test name, x (hex), y (hex), expected product (hex), idle cycles after it (decimal).
# Lines that start with # are skipped.
zero_zero      0000 0000 00000000 0
zero_ones      0000 ffff 00000000 0
ones_zero      ffff 0000 00000000 1
one_one        0001 0001 00000001 0
one_times_a    0001 a5c3 0000a5c3 0
a_times_one    1234 0001 00001234 2
max_max        ffff ffff fffe0001 0
bit15_bit15    8000 8000 40000000 0
bit15_ones     8000 ffff 7fff8000 3
ones_bit15     ffff 8000 7fff8000 0
bit0_bit15     0001 8000 00008000 0
bit7_bit8      0080 0100 00008000 0
bit1_bit14     0002 4000 00008000 1
bit14_bit14    4000 4000 10000000 0
bit15_bit0     8000 0001 00008000 0
bit15_bit1     8000 0002 00010000 0
bit14_bit2     4000 0004 00010000 2
two_ones       0002 ffff 0001fffe 0
ones_two       ffff 0002 0001fffe 0
three_three    0003 0003 00000009 0
two_two        0002 0002 00000004 1
alt_mixed      aaaa 5555 38e31c72 0
alt_alt        aaaa aaaa 71c638e4 0
alt5_alt5      5555 5555 1c718e39 0
alt_ones       aaaa ffff aaa95556 0
alt5_ones      5555 ffff 5554aaab 4
low_byte_sq    00ff 00ff 0000fe01 0
high_low_byte  ff00 00ff 00fe0100 0
high_byte_sq   ff00 ff00 fe010000 0
bit8_bit8      0100 0100 00010000 0
ones_bit8      ffff 0100 00ffff00 0
bit8_ones      0100 ffff 00ffff00 1
nibbles        0f0f f0f0 0e2c2e10 0
hex_digits     1234 5678 06260060 0
ones_one       ffff 0001 0000ffff 0
half_max_sq    7fff 7fff 3fff0001 0
ones_half_max  ffff 7fff 7ffe8001 2
ends_sq        8001 8001 40010001 0
fffe_sq        fffe fffe fffc0004 0
top_two_sq     c000 c000 90000000 0

//--- csam16_pipe.f
src/csam_pkg.sv
src/csam_first_row.sv
src/csam_row_segment.sv
src/csam_final_adder.sv
src/csam16_pipe.sv
testbench/clock_gen.sv
testbench/tb_csam16_pipe.sv
